//--- src.f
+incdir+include
verilog/hdmiPkg.sv
verilog/videoTiming.sv
verilog/islandPacker.sv
verilog/tmdsEncoder.sv
verilog/terc4Encoder.sv
verilog/symbolMux.sv
verilog/hdmiTx.sv
verification/hdmiTxTb.sv

//--- Makefile
# Verilator build and run for the HDMI transmitter testbench

VERILATOR ?= verilator
TOP ?= hdmiTxTb
FILELIST ?= src.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_MSG ?= all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- include/tbModel.svh
// testbench reference model
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

typedef enum {posActive, posControl, posDataPreamble, posVideoPreamble,
	posDataGuard, posPacket, posVideoGuard} posClassT;

// TERC4 code words indexed by the nibble
localparam symbolT terc4Codes [16] = '{
	10'b1010011100, 10'b1001100011, 10'b1011100100, 10'b1011100010,
	10'b0101110001, 10'b0100011110, 10'b0110001110, 10'b0100111100,
	10'b1011001100, 10'b0100111001, 10'b0110011100, 10'b1011000110,
	10'b1010001110, 10'b1001110001, 10'b0101100011, 10'b1011000011
};

////////////////////
// raster rules
function automatic logic hSyncAt(int col);
	return col >= displayWidth + hFrontPorch && col < displayWidth + hFrontPorch + hSyncWidth;
endfunction

function automatic logic vSyncAt(int line);
	return line >= displayHeight + vFrontPorch && line < displayHeight + vFrontPorch + vSyncWidth;
endfunction

function automatic posClassT classAt(int col, int line);
	int islandCol;
	islandCol = col - dataStart - dataPreambleLen;  // 0 at the lead guard
	if (col < displayWidth && line < displayHeight)
		return posActive;
	if (col >= dataStart && islandCol < 0)
		return posDataPreamble;
	if (islandCol >= 0 && islandCol < guardLen)
		return posDataGuard;
	if (islandCol >= guardLen && islandCol < guardLen + packetLen)
		return posPacket;
	if (islandCol >= guardLen + packetLen && islandCol < 2 * guardLen + packetLen)
		return posDataGuard;
	if (col >= fullWidth - guardLen)
		return posVideoGuard;
	if (col >= ctlEnd)
		return posVideoPreamble;
	return posControl;
endfunction

////////////////////
// symbol decoding
function automatic colorT tmdsDecode(symbolT sym);
	logic [7:0] q;
	colorT d;
	q = sym[9] ? ~sym[7:0] : sym[7:0];  // undo the inversion
	d[0] = q[0];
	for (int i = 1; i < 8; i++)
		d[i] = sym[8] ? (q[i] ^ q[i-1]) : ~(q[i] ^ q[i-1]);
	return d;
endfunction

function automatic int terc4Decode(symbolT sym);
	for (int i = 0; i < 16; i++)
		if (terc4Codes[i] == sym)
			return i;
	return -1;  // not a TERC4 word
endfunction

function automatic int onesMinusZeros(symbolT sym);
	return 2 * $countones(sym) - 10;
endfunction

////////////////////
// AVI packet content
function automatic parityT bchOver(logic [55:0] bits, int count);
	parityT r;
	logic msb;
	r = '0;
	for (int i = 0; i < count; i++) begin
		msb = r[7];
		r = r << 1;
		if (msb != bits[i])
			r = r ^ bchPoly;
	end
	return r;
endfunction

function automatic subpacketT subpacketAt(int i);
	case (i)
		0: return aviSubpacket0;
		1: return aviSubpacket1;
		default: return '0;
	endcase
endfunction

function automatic nibbleT expectCh0(int cycle, logic v, logic h);
	parityT parity;
	logic hdrBit;
	parity = bchOver(56'(aviHeader), $bits(headerT));
	if (cycle < $bits(headerT))
		hdrBit = aviHeader[cycle];
	else
		hdrBit = parity[7 - (cycle - $bits(headerT))];  // msb first
	return {cycle != 0, hdrBit, v, h};
endfunction

// odd 0 gives the green nibble and odd 1 the red one
function automatic nibbleT expectSubBits(int cycle, int odd);
	subpacketT sub;
	parityT parity;
	nibbleT bits;
	for (int i = 0; i < 4; i++) begin
		sub = subpacketAt(i);
		parity = bchOver(sub, $bits(subpacketT));
		if (cycle < $bits(subpacketT) / 2)
			bits[i] = sub[2 * cycle + odd];
		else
			bits[i] = parity[7 - 2 * (cycle - $bits(subpacketT) / 2) - odd];
	end
	return bits;
endfunction

`endif

//--- verification/hdmiTxTb.sv
// HDMI transmitter testbench
`timescale 1ns/100ps

module hdmiTxTb import hdmiPkg::*; ();

	`include "tbModel.svh"

	localparam int latency = 3;
	localparam int runPositions = fullWidth * (fullHeight + 20);  // a frame and 20 lines
	localparam int runEdges = runPositions + latency - 1;
	localparam int cycleLimit = runEdges + 3 + 100;  // reset cycles plus margin
	localparam int numTests = 5;
	localparam int testReset = 0;
	localparam int testControl = 1;
	localparam int testActive = 2;
	localparam int testGuard = 3;
	localparam int testIsland = 4;

	logic pixclk;
	logic arstN;
	logic [23:0] rgb;
	symbolT tmdsRed, tmdsGreen, tmdsBlue;

	string testNames [numTests] = '{"reset", "control", "active", "guard", "island"};
	int checkCount [numTests] = '{default: 0};
	int errorCount [numTests] = '{default: 0};
	int runDisp [3] = '{default: 0};  // ones minus zeros per channel
	logic [15:0] lfsrState;
	logic [23:0] rgbQueue [$];
	int curLine = -1;
	int curCol = 0;
	int cycleCount;

	hdmiTx i_dut (.pixclk, .arstN, .rgb, .tmdsRed, .tmdsGreen, .tmdsBlue);

	initial begin
		pixclk = 1'b0;
		forever #2 pixclk = ~pixclk;
	end

	////////////////////
	// stimulus
	function automatic logic [15:0] lfsrNext(logic [15:0] state);
		return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
	endfunction

	task automatic drawRgb(output logic [23:0] value);
		value = '0;
		for (int b = 0; b < 24; b++) begin
			lfsrState = lfsrNext(lfsrState);  // one step per bit
			value = {value[22:0], lfsrState[0]};
		end
	endtask

	////////////////////
	// compare tasks
	function automatic string placeText();
		if (curLine < 0)
			return "before position 0";
		return $sformatf("line %0d col %0d", curLine, curCol);
	endfunction

	task automatic compareSymbol(int test, string what, symbolT expected, symbolT actual);
		checkCount[test]++;
		if (actual !== expected) begin
			errorCount[test]++;
			$display("FAIL %s %s %s: expected %b, actual %b",
				testNames[test], what, placeText(), expected, actual);
		end
	endtask

	task automatic compareColor(int test, string what, colorT expected, colorT actual);
		checkCount[test]++;
		if (actual !== expected) begin
			errorCount[test]++;
			$display("FAIL %s %s %s: expected %h, actual %h",
				testNames[test], what, placeText(), expected, actual);
		end
	endtask

	task automatic compareNibble(int test, string what, nibbleT expected, nibbleT actual);
		checkCount[test]++;
		if (actual !== expected) begin
			errorCount[test]++;
			$display("FAIL %s %s %s: expected %h, actual %h",
				testNames[test], what, placeText(), expected, actual);
		end
	endtask

	task automatic decodeTerc(int test, string what, nibbleT expected, symbolT sym);
		int code;
		code = terc4Decode(sym);
		if (code < 0) begin
			checkCount[test]++;
			errorCount[test]++;
			$display("%s: %s carries %b at %s, which is no TERC4 word",
				testNames[test], what, sym, placeText());
		end else begin
			compareNibble(test, what, expected, nibbleT'(code));
		end
	endtask

	task automatic trackDisparity(int ch, string what, symbolT sym);
		runDisp[ch] += onesMinusZeros(sym);
		checkCount[testActive]++;
		if (runDisp[ch] > 10 || runDisp[ch] < -10) begin
			errorCount[testActive]++;
			$display("active: running disparity on %s reached %0d at %s",
				what, runDisp[ch], placeText());
		end
	endtask

	task automatic checkPosition(int pos, logic [23:0] pixel);
		logic v, h;
		symbolT blueCtl;
		int cycle;
		curCol = pos % fullWidth;
		curLine = (pos / fullWidth) % fullHeight;
		v = vSyncAt(curLine);
		h = hSyncAt(curCol);
		blueCtl = ctlCodes[{v, h}];
		if (curCol == 0)
			runDisp = '{default: 0};  // encoder restarts balance each line
		case (classAt(curCol, curLine))
			posActive: begin
				compareColor(testActive, "red", pixel[23:16], tmdsDecode(tmdsRed));
				compareColor(testActive, "green", pixel[15:8], tmdsDecode(tmdsGreen));
				compareColor(testActive, "blue", pixel[7:0], tmdsDecode(tmdsBlue));
				trackDisparity(0, "red", tmdsRed);
				trackDisparity(1, "green", tmdsGreen);
				trackDisparity(2, "blue", tmdsBlue);
			end
			posDataGuard: begin
				compareSymbol(testGuard, "red", dataVideoGuardG, tmdsRed);
				compareSymbol(testGuard, "green", dataVideoGuardG, tmdsGreen);
				decodeTerc(testGuard, "blue", {2'b11, v, h}, tmdsBlue);
			end
			posVideoGuard: begin
				compareSymbol(testGuard, "red", videoGuardRb, tmdsRed);
				compareSymbol(testGuard, "green", dataVideoGuardG, tmdsGreen);
				compareSymbol(testGuard, "blue", videoGuardRb, tmdsBlue);
			end
			posPacket: begin
				cycle = curCol - dataStart - dataPreambleLen - guardLen;
				decodeTerc(testIsland, "blue", expectCh0(cycle, v, h), tmdsBlue);
				decodeTerc(testIsland, "green", expectSubBits(cycle, 0), tmdsGreen);
				decodeTerc(testIsland, "red", expectSubBits(cycle, 1), tmdsRed);
			end
			default: begin
				// 01 on both in the data preamble and on green in the video preamble
				compareSymbol(testControl, "red",
					ctlCodes[(classAt(curCol, curLine) == posDataPreamble) ? 1 : 0], tmdsRed);
				compareSymbol(testControl, "green",
					ctlCodes[(classAt(curCol, curLine) == posControl) ? 0 : 1], tmdsGreen);
				compareSymbol(testControl, "blue", blueCtl, tmdsBlue);
			end
		endcase
	endtask

	task automatic checkResetCodes();
		compareSymbol(testReset, "red", ctlCodes[0], tmdsRed);
		compareSymbol(testReset, "green", ctlCodes[0], tmdsGreen);
		compareSymbol(testReset, "blue", ctlCodes[0], tmdsBlue);
	endtask

	task automatic reportTest(int test);
		if (checkCount[test] == 0) begin
			errorCount[test]++;
			$display("%s: no checks were made", testNames[test]);
		end
		$display("%s: %0d checks, %0d errors", testNames[test], checkCount[test],
			errorCount[test]);
	endtask

	////////////////////
	// run
	initial begin : mainFlow
		logic [23:0] pixel;
		int totalChecks;
		int totalErrors;
		arstN = 1'b0;
		rgb = '0;
		lfsrState = 16'd80;
		totalChecks = 0;
		totalErrors = 0;
		repeat (3) @(posedge pixclk);
		#1;
		checkResetCodes();
		arstN = 1'b1;
		for (int n = 1; n <= runEdges; n++) begin
			@(posedge pixclk);
			#1;
			drawRgb(pixel);
			rgb = pixel;  // belongs to position n-1
			rgbQueue.push_back(pixel);
			if (n < latency) begin
				checkResetCodes();
			end else begin
				if (n == latency)
					reportTest(testReset);
				checkPosition(n - latency, rgbQueue.pop_front());
			end
		end
		for (int t = testControl; t < numTests; t++)
			reportTest(t);
		for (int t = 0; t < numTests; t++) begin
			totalChecks += checkCount[t];
			totalErrors += errorCount[t];
		end
		$display("total: %0d checks, %0d errors", totalChecks, totalErrors);
		if (totalErrors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	initial begin : watchdog
		cycleCount = 0;
		while (cycleCount < cycleLimit) begin
			@(posedge pixclk);
			cycleCount++;
		end
		$display("timeout: the run did not end within %0d cycles", cycleLimit);
		$display("tests failed");
		$finish;
	end

endmodule

//--- verilog/hdmiTx.sv
// HDMI source transmitter
// 640x480 at one pixel per clock
`timescale 1ns/100ps

module hdmiTx import hdmiPkg::*; (
	input logic pixclk,
	input logic arstN,
	input logic [23:0] rgb,      // red in the top byte
	output symbolT tmdsRed,
	output symbolT tmdsGreen,
	output symbolT tmdsBlue
);

	islandPhaseT islandPhase;
	logic hSync, vSync, drawArea, videoGuard;
	ctlT ctlRed, ctlGreen;
	logic tercData, dataGuard;
	nibbleT dataCh0, dataCh1, dataCh2;
	symbolT tmdsR, tmdsG, tmdsB;
	symbolT tercR, tercG, tercB;

	////////////////////
	// stage 0 and 1
	videoTiming i_videoTiming (.pixclk, .arstN, .column(), .islandPhase, .hSync, .vSync,
		.drawArea, .videoGuard, .ctlRed, .ctlGreen);

	islandPacker i_islandPacker (.pixclk, .arstN, .islandPhase, .hSync, .vSync,
		.tercData, .dataGuard, .dataCh0, .dataCh1, .dataCh2);

	////////////////////
	// stage 2 encoders
	tmdsEncoder i_tmdsRed (.pixclk, .arstN, .videoData(rgb[23:16]), .ctlData(ctlRed),
		.dataEnable(drawArea), .symbol(tmdsR));
	tmdsEncoder i_tmdsGreen (.pixclk, .arstN, .videoData(rgb[15:8]), .ctlData(ctlGreen),
		.dataEnable(drawArea), .symbol(tmdsG));
	tmdsEncoder i_tmdsBlue (.pixclk, .arstN, .videoData(rgb[7:0]), .ctlData({vSync, hSync}),
		.dataEnable(drawArea), .symbol(tmdsB));

	terc4Encoder i_tercRed (.pixclk, .arstN, .data(dataCh2), .symbol(tercR));
	terc4Encoder i_tercGreen (.pixclk, .arstN, .data(dataCh1), .symbol(tercG));
	terc4Encoder i_tercBlue (.pixclk, .arstN, .data(dataCh0), .symbol(tercB));

	// stage 3 output select
	symbolMux i_symbolMux (
		.pixclk,
		.arstN,
		.tercData,
		.dataGuard,
		.videoGuard,
		.tmdsR,
		.tmdsG,
		.tmdsB,
		.tercR,
		.tercG,
		.tercB,
		.tmdsRed,
		.tmdsGreen,
		.tmdsBlue
	);

endmodule

//--- verilog/symbolMux.sv
// channel symbol select
// guard bands over TERC4 over TMDS
`timescale 1ns/100ps

module symbolMux import hdmiPkg::*; (
	input logic pixclk,
	input logic arstN,
	input logic tercData,
	input logic dataGuard,
	input logic videoGuard,
	input symbolT tmdsR,
	input symbolT tmdsG,
	input symbolT tmdsB,
	input symbolT tercR,
	input symbolT tercG,
	input symbolT tercB,
	output symbolT tmdsRed,
	output symbolT tmdsGreen,
	output symbolT tmdsBlue
);

	// flags lined up with the encoder outputs
	logic tercDataDly;
	logic dataGuardDly;
	logic videoGuardDly;

	always_ff @(posedge pixclk or negedge arstN) begin
		if (!arstN) begin
			tercDataDly <= 1'b0;
			dataGuardDly <= 1'b0;
			videoGuardDly <= 1'b0;
			tmdsRed <= ctlCodes[0];
			tmdsGreen <= ctlCodes[0];
			tmdsBlue <= ctlCodes[0];
		end else begin
			tercDataDly <= tercData;
			dataGuardDly <= dataGuard;
			videoGuardDly <= videoGuard;
			if (videoGuardDly) begin
				tmdsRed <= videoGuardRb;
				tmdsGreen <= dataVideoGuardG;
				tmdsBlue <= videoGuardRb;
			end else if (dataGuardDly) begin
				tmdsRed <= dataVideoGuardG;
				tmdsGreen <= dataVideoGuardG;
				tmdsBlue <= tercB;  // carries the sync nibble
			end else if (tercDataDly) begin
				tmdsRed <= tercR;
				tmdsGreen <= tercG;
				tmdsBlue <= tercB;
			end else begin
				tmdsRed <= tmdsR;
				tmdsGreen <= tmdsG;
				tmdsBlue <= tmdsB;
			end
		end
	end

	guardExclusive: assert property (@(posedge pixclk) disable iff (!arstN)
		!(dataGuard && videoGuard));

endmodule

//--- verilog/terc4Encoder.sv
// TERC4 encoder
`timescale 1ns/100ps

module terc4Encoder import hdmiPkg::*; (
	input logic pixclk,
	input logic arstN,
	input nibbleT data,
	output symbolT symbol
);

	always_ff @(posedge pixclk or negedge arstN) begin
		if (!arstN) begin
			symbol <= '0;
		end else begin
			case (data)
				4'h0: symbol <= 10'b1010011100;
				4'h1: symbol <= 10'b1001100011;
				4'h2: symbol <= 10'b1011100100;
				4'h3: symbol <= 10'b1011100010;
				4'h4: symbol <= 10'b0101110001;
				4'h5: symbol <= 10'b0100011110;
				4'h6: symbol <= 10'b0110001110;
				4'h7: symbol <= 10'b0100111100;
				4'h8: symbol <= 10'b1011001100;
				4'h9: symbol <= 10'b0100111001;
				4'hA: symbol <= 10'b0110011100;
				4'hB: symbol <= 10'b1011000110;
				4'hC: symbol <= 10'b1010001110;
				4'hD: symbol <= 10'b1001110001;
				4'hE: symbol <= 10'b0101100011;
				default: symbol <= 10'b1011000011;  // 4'hF
			endcase
		end
	end

endmodule

//--- verilog/tmdsEncoder.sv
// TMDS video encoder
`timescale 1ns/100ps

module tmdsEncoder import hdmiPkg::*; (
	input logic pixclk,
	input logic arstN,
	input colorT videoData,
	input ctlT ctlData,
	input logic dataEnable,
	output symbolT symbol
);

	logic [3:0] onesData;
	logic useXnor;
	logic [8:0] qm;                  // transition minimised word
	logic signed [4:0] balance;      // ones minus four in qm[7:0]
	logic signed [4:0] disparity;    // running disparity in half units
	logic signed [4:0] disparityNext;
	logic invert;

	always_comb begin
		onesData = 4'($countones(videoData));
		useXnor = (onesData > 4'd4) || (onesData == 4'd4 && !videoData[0]);
		qm[0] = videoData[0];
		for (int i = 1; i < 8; i++)
			qm[i] = qm[i-1] ^ videoData[i] ^ useXnor;
		qm[8] = !useXnor;
		balance = 5'($countones(qm[7:0])) - 5'd4;

		// DC balancing
		if (disparity == 0 || balance == 0) begin
			invert = !qm[8];
			disparityNext = qm[8] ? disparity + balance : disparity - balance;
		end else if (disparity[4] == balance[4]) begin
			invert = 1'b1;  // equal signs flip the word
			disparityNext = disparity + $signed({4'd0, qm[8]}) - balance;
		end else begin
			invert = 1'b0;
			disparityNext = disparity - $signed({4'd0, !qm[8]}) + balance;
		end
	end

	always_ff @(posedge pixclk or negedge arstN) begin
		if (!arstN) begin
			symbol <= ctlCodes[0];
			disparity <= '0;
		end else if (dataEnable) begin
			symbol <= {invert, qm[8], qm[7:0] ^ {8{invert}}};
			disparity <= disparityNext;
		end else begin
			symbol <= ctlCodes[ctlData];  // control period
			disparity <= '0;
		end
	end

	dispCleared: assert property (@(posedge pixclk) disable iff (!arstN)
		$fell(dataEnable) |=> disparity == '0);

endmodule

//--- verilog/islandPacker.sv
// data island packer
// AVI packet bits, BCH parity and TERC4 nibbles
`timescale 1ns/100ps

module islandPacker import hdmiPkg::*; (
	input logic pixclk,
	input logic arstN,
	input islandPhaseT islandPhase,
	input logic hSync,
	input logic vSync,
	output logic tercData,
	output logic dataGuard,
	output nibbleT dataCh0,
	output nibbleT dataCh1,
	output nibbleT dataCh2
);

	headerT headerSr;
	subpacketT subSr [4];
	parityT hdrParity;
	parityT subParity [4];
	logic [4:0] packetOffset;  // cycle within the packet

	logic hdrSending;
	logic subSending;
	logic hdrBit;
	nibbleT evenBits;
	nibbleT oddBits;
	parityT hdrParityNext;
	parityT subParityNext [4];

	// one bit into the BCH remainder
	function automatic parityT bchStep(parityT remainder, logic dataBit);
		bchStep = {remainder[6:0], 1'b0} ^ ((remainder[7] ^ dataBit) ? bchPoly : '0);
	endfunction

	////////////////////
	// data or parity per channel
	always_comb begin
		hdrSending = packetOffset < 5'($bits(headerT));
		subSending = packetOffset < 5'($bits(subpacketT) / 2);
		hdrBit = hdrSending ? headerSr[0] : hdrParity[7];  // parity msb first
		hdrParityNext = hdrSending ? bchStep(hdrParity, headerSr[0]) : {hdrParity[6:0], 1'b0};
		for (int i = 0; i < 4; i++) begin
			if (subSending) begin
				evenBits[i] = subSr[i][0];
				oddBits[i] = subSr[i][1];
				subParityNext[i] = bchStep(bchStep(subParity[i], subSr[i][0]), subSr[i][1]);
			end else begin
				evenBits[i] = subParity[i][7];
				oddBits[i] = subParity[i][6];
				subParityNext[i] = {subParity[i][5:0], 2'b00};
			end
		end
	end

	// packet shift registers and remainders
	always_ff @(posedge pixclk or negedge arstN) begin
		if (!arstN) begin
			headerSr <= '0;
			hdrParity <= '0;
			for (int i = 0; i < 4; i++) begin
				subSr[i] <= '0;
				subParity[i] <= '0;
			end
		end else if (islandPhase == islandLeadGuard) begin
			headerSr <= aviHeader;
			subSr[0] <= aviSubpacket0;
			subSr[1] <= aviSubpacket1;
			subSr[2] <= '0;
			subSr[3] <= '0;
			hdrParity <= '0;
			for (int i = 0; i < 4; i++)
				subParity[i] <= '0;
		end else if (islandPhase == islandPacket) begin
			headerSr <= headerSr >> 1;
			hdrParity <= hdrParityNext;
			for (int i = 0; i < 4; i++) begin
				subSr[i] <= subSr[i] >> 2;
				subParity[i] <= subParityNext[i];
			end
		end
	end

	////////////////////
	// stage 1 outputs
	always_ff @(posedge pixclk or negedge arstN) begin
		if (!arstN) begin
			tercData <= 1'b0;
			dataGuard <= 1'b0;
			packetOffset <= '0;
			dataCh0 <= '0;
			dataCh1 <= '0;
			dataCh2 <= '0;
		end else begin
			tercData <= islandPhase inside {islandLeadGuard, islandPacket, islandTrailGuard};
			dataGuard <= islandPhase inside {islandLeadGuard, islandTrailGuard};
			case (islandPhase)
				islandLeadGuard: begin
					packetOffset <= '0;
					dataCh0 <= {2'b11, vSync, hSync};
				end
				islandPacket: begin
					packetOffset <= packetOffset + 1'b1;
					dataCh0 <= {packetOffset != '0, hdrBit, vSync, hSync};  // bit 3 low on first
					dataCh1 <= evenBits;
					dataCh2 <= oddBits;
				end
				islandTrailGuard: dataCh0 <= {2'b11, vSync, hSync};
				default: ;
			endcase
		end
	end

	offsetHold: assert property (@(posedge pixclk) disable iff (!arstN)
		islandPhase != islandPacket |=>
			(packetOffset == $past(packetOffset)) || (packetOffset == '0));

endmodule

//--- verilog/videoTiming.sv
// raster timing
// counters, sync and line periods
`timescale 1ns/100ps

module videoTiming import hdmiPkg::*; (
	input logic pixclk,
	input logic arstN,
	output pixelCoordT column,
	output islandPhaseT islandPhase,
	output logic hSync,
	output logic vSync,
	output logic drawArea,
	output logic videoGuard,
	output ctlT ctlRed,
	output ctlT ctlGreen
);

	pixelCoordT lineCnt;

	////////////////////
	// stage 0 counters
	always_ff @(posedge pixclk or negedge arstN) begin
		if (!arstN) begin
			column <= '0;
			lineCnt <= '0;
		end else if (column == pixelCoordT'(fullWidth - 1)) begin
			column <= '0;
			lineCnt <= (lineCnt == pixelCoordT'(fullHeight - 1)) ? '0 : lineCnt + 1'b1;
		end else begin
			column <= column + 1'b1;
		end
	end

	// island periods straight from the column
	always_comb begin
		if (column < dataStart)
			islandPhase = islandIdle;
		else if (column < dataStart + dataPreambleLen)
			islandPhase = islandPreamble;
		else if (column < dataStart + dataPreambleLen + guardLen)
			islandPhase = islandLeadGuard;
		else if (column < dataStart + dataPreambleLen + guardLen + packetLen)
			islandPhase = islandPacket;
		else if (column < dataStart + dataPreambleLen + 2 * guardLen + packetLen)
			islandPhase = islandTrailGuard;
		else
			islandPhase = islandIdle;
	end

	////////////////////
	// stage 1 registers
	always_ff @(posedge pixclk or negedge arstN) begin
		if (!arstN) begin
			hSync <= 1'b0;
			vSync <= 1'b0;
			drawArea <= 1'b0;
			videoGuard <= 1'b0;
			ctlRed <= 2'b00;
			ctlGreen <= 2'b00;
		end else begin
			hSync <= (column >= displayWidth + hFrontPorch) &&
				(column < displayWidth + hFrontPorch + hSyncWidth);
			vSync <= (lineCnt >= displayHeight + vFrontPorch) &&
				(lineCnt < displayHeight + vFrontPorch + vSyncWidth);
			drawArea <= (column < displayWidth) && (lineCnt < displayHeight);
			videoGuard <= column >= fullWidth - guardLen;
			if (islandPhase == islandPreamble) begin
				ctlRed <= 2'b01;  // data preamble
				ctlGreen <= 2'b01;
			end else if (column >= ctlEnd && column < fullWidth - guardLen) begin
				ctlRed <= 2'b00;  // video preamble
				ctlGreen <= 2'b01;
			end else begin
				ctlRed <= 2'b00;
				ctlGreen <= 2'b00;
			end
		end
	end

	colInRange: assert property (@(posedge pixclk) disable iff (!arstN)
		column < pixelCoordT'(fullWidth));

endmodule

//--- verilog/hdmiPkg.sv
// HDMI transmitter
// shared timing, code words and types
package hdmiPkg;

	typedef logic [9:0] pixelCoordT;
	typedef logic [7:0] colorT;
	typedef logic [1:0] ctlT;
	typedef logic [3:0] nibbleT;
	typedef logic [9:0] symbolT;
	typedef logic [23:0] headerT;
	typedef logic [55:0] subpacketT;
	typedef logic [7:0] parityT;

	typedef enum logic [2:0] {
		islandIdle,
		islandPreamble,
		islandLeadGuard,
		islandPacket,
		islandTrailGuard
	} islandPhaseT;

	////////////////////
	// 640x480 raster
	localparam int displayWidth = 640;
	localparam int displayHeight = 480;
	localparam int fullWidth = 768;
	localparam int fullHeight = 528;
	localparam int hFrontPorch = 16;
	localparam int hSyncWidth = 96;
	localparam int vFrontPorch = 10;
	localparam int vSyncWidth = 2;

	localparam int dataStart = 660;      // first island column
	localparam int dataPreambleLen = 8;
	localparam int guardLen = 2;
	localparam int packetLen = 32;
	localparam int ctlEnd = fullWidth - dataPreambleLen - guardLen; // video preamble start

	////////////////////
	// code words
	localparam symbolT ctlCodes [4] = '{
		10'b1101010100,
		10'b0010101011,
		10'b0101010100,
		10'b1010101011
	};
	localparam symbolT videoGuardRb = 10'b1011001100;
	localparam symbolT dataVideoGuardG = 10'b0100110011;

	// AVI infoframe
	localparam headerT aviHeader = 24'h0D0282;
	localparam subpacketT aviSubpacket0 = 56'h0000010019107B;
	localparam subpacketT aviSubpacket1 = 56'h0501000005BF00;

	localparam parityT bchPoly = 8'hC1;  // x^8 + x^7 + x^6 + 1 taps

endpackage
